//--- hw/flow_sched_pkg.sv
/*
 * Shared definitions for the packet scheduler.
 * Holds the scheduler state type and the default stream widths that the
 * top level and the stream interface fall back on.
 */

package flow_sched_pkg;

  // ----------------------------------------------------------------------
  // Scheduler state
  // ----------------------------------------------------------------------

  // SCAN walks the flows looking for a valid beat
  // GRANT keeps one flow on the output until its packet ends
  typedef enum logic {
    SCHED_SCAN  = 1'b0,
    SCHED_GRANT = 1'b1
  } sched_state_e;

  // ----------------------------------------------------------------------
  // Default widths
  // ----------------------------------------------------------------------

  // Flow number width, two bits gives four flows
  localparam int FLOW_ID_W_DEFAULT = 2;

  // Width of one data beat
  localparam int DATA_W_DEFAULT = 16;

endpackage

//--- hw/flow_if.sv
/*
 * Ready-valid stream carrying packet beats tagged with their flow number.
 * The src side drives the beat, the snk side answers with ready, and mon
 * is a read-only view for blocks that only watch transfers.
 */

interface flow_if import flow_sched_pkg::*; #(
  parameter int BitWidth = DATA_W_DEFAULT,
  parameter int NumFlows = 2 ** FLOW_ID_W_DEFAULT
) ();

  // Beat qualifier and back-pressure
  logic                        valid;
  logic                        ready;
  // Payload, end-of-packet marker and source flow tag
  logic [BitWidth-1:0]         data;
  logic                        last;
  logic [$clog2(NumFlows)-1:0] flow;

  // Producer of beats
  modport src (output valid, output data, output last, output flow, input ready);

  // Consumer of beats
  modport snk (input valid, input data, input last, input flow, output ready);

  // Observer, sees every signal and drives none
  modport mon (input valid, input ready, input data, input last, input flow);

endinterface

//--- hw/flow_mux_select.sv
/*
 * Combinational flow mux with explicit select and a grant gate.
 * Forwards the selected flow onto the output stream and returns ready to
 * that flow only, tagging each beat with the select value. Zero latency.
 */

module flow_mux_select import flow_sched_pkg::*; #(
  // At least 2
  parameter int NumFlows = 2 ** FLOW_ID_W_DEFAULT,
  // At least 1
  parameter int BitWidth = DATA_W_DEFAULT
) (
  // Clock and reset only feed the range check below
  input  logic                              clk,
  input  logic                              reset,

  input  logic [$clog2(NumFlows)-1:0]       select,
  input  logic                              grant,

  input  logic [NumFlows-1:0]               push_valid,
  input  logic [NumFlows-1:0][BitWidth-1:0] push_data,
  input  logic [NumFlows-1:0]               push_last,
  output logic [NumFlows-1:0]               push_ready,

  flow_if.src                               out
);

  // ----------------------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------------------

  // Output ready goes back to the selected flow only, and only in a grant
  assign push_ready = NumFlows'(out.ready & grant) << select;

  // No beat leaves while the scheduler is still scanning
  assign out.valid = grant & push_valid[select];
  assign out.data  = push_data[select];
  assign out.last  = push_last[select];

  // Tag the beat with its source flow
  assign out.flow  = select;

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // With a non power of two flow count the upper codes are illegal
  select_in_range_a : assert property (
    @(posedge clk) disable iff (reset) select < NumFlows
  ) else $error("flow_mux_select: select %0d out of range", select);

endmodule

//--- hw/flow_sched_fsm.sv
/*
 * Round-robin packet scheduler.
 * Scans one flow per cycle, grants the first valid one and keeps the grant
 * until a packet ends with the beat budget used up or the flow goes idle.
 */

module flow_sched_fsm import flow_sched_pkg::*; #(
  // At least 2
  parameter int NumFlows = 2 ** FLOW_ID_W_DEFAULT
) (
  input  logic                        clk,
  input  logic                        reset,

  // Per-flow valid, used to spot waiting packets
  input  logic [NumFlows-1:0]         push_valid,

  // Muxed output stream, watched for transfers
  flow_if.mon                         mon,

  // From the beat-budget timer
  input  logic                        budget_reached,

  // To the mux and the timer
  output logic [$clog2(NumFlows)-1:0] select,
  output logic                        grant,
  output logic                        grant_start
);

  localparam int SelW = $clog2(NumFlows);

  sched_state_e    state;
  // Set for the one cycle that follows a last-beat transfer
  logic            after_last;
  logic            last_xfer;
  logic [SelW-1:0] select_next;

  // ----------------------------------------------------------------------
  // Decode
  // ----------------------------------------------------------------------

  // Next flow in round-robin order, wrapping at NumFlows
  assign select_next = (select == SelW'(NumFlows - 1)) ? '0 : select + 1'b1;

  // End of a packet on the output
  assign last_xfer = mon.valid & mon.ready & mon.last;

  assign grant = (state == SCHED_GRANT);

  // Pulses on the scan cycle that finds a valid flow
  assign grant_start = (state == SCHED_SCAN) & push_valid[select];

  // ----------------------------------------------------------------------
  // State register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= SCHED_SCAN;
      select     <= '0;
      after_last <= 1'b0;
    end else begin
      case (state)
        SCHED_SCAN: begin
          after_last <= 1'b0;
          // Hold select on a hit so the grant goes to that flow
          if (push_valid[select]) begin
            state <= SCHED_GRANT;
          end else begin
            select <= select_next;
          end
        end

        SCHED_GRANT: begin
          if (last_xfer) begin
            if (budget_reached) begin
              // Budget spent, hand over to the next flow
              state  <= SCHED_SCAN;
              select <= select_next;
            end else begin
              after_last <= 1'b1;
            end
          end else if (after_last) begin
            after_last <= 1'b0;
            // Flow has nothing more queued, give up the grant
            if (!push_valid[select]) begin
              state  <= SCHED_SCAN;
              select <= select_next;
            end
          end
        end
      endcase
    end
  end

endmodule

//--- hw/beat_budget_timer.sv
/*
 * Beat-budget timer for one grant.
 * Counts beats accepted on the output since grant_start and flags when the
 * count, with the beat moving now, reaches the budget.
 */

module beat_budget_timer #(
  // Beats per grant, at least 1
  parameter int BurstBeats = 8
) (
  input  logic clk,
  input  logic reset,
  input  logic grant_start,
  flow_if.mon  mon,
  output logic budget_reached
);

  localparam int CntW = $clog2(BurstBeats + 1);
  // One extra bit so the current beat can be added without overflow
  localparam int SumW = CntW + 1;

  logic [CntW-1:0] count;
  logic [SumW-1:0] beats_now;
  logic            xfer;

  assign xfer = mon.valid & mon.ready;

  // Count as it stands once the current beat is included
  assign beats_now = {1'b0, count} + SumW'(xfer);

  assign budget_reached = (beats_now >= SumW'(BurstBeats));

  // ----------------------------------------------------------------------
  // Counter
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (grant_start) begin
      count <= '0;
    end else if (xfer && !budget_reached) begin
      count <= count + 1'b1;
    end else if (xfer) begin
      // Saturate, a long packet may run past the budget
      count <= CntW'(BurstBeats);
    end
  end

endmodule

//--- hw/flow_skid_buffer.sv
/*
 * Two-entry output stage for the scheduled stream.
 * A main register feeds the pop side and a skid register catches the beat
 * in flight when pop_ready drops. Push ready comes straight from a flop.
 */

module flow_skid_buffer import flow_sched_pkg::*; #(
  parameter int BitWidth = DATA_W_DEFAULT,
  parameter int NumFlows = 2 ** FLOW_ID_W_DEFAULT
) (
  input  logic                        clk,
  input  logic                        reset,

  flow_if.snk                         push,

  output logic                        pop_valid,
  input  logic                        pop_ready,
  output logic [BitWidth-1:0]         pop_data,
  output logic                        pop_last,
  output logic [$clog2(NumFlows)-1:0] pop_flow
);

  localparam int SelW = $clog2(NumFlows);

  logic                main_valid;
  logic [BitWidth-1:0] main_data;
  logic                main_last;
  logic [SelW-1:0]     main_flow;

  logic                skid_valid;
  logic [BitWidth-1:0] skid_data;
  logic                skid_last;
  logic [SelW-1:0]     skid_flow;

  logic                ready_q;
  logic                push_xfer;
  // Main entry is free or emptying this cycle
  logic                main_load;

  assign push_xfer  = push.valid & push.ready;
  assign main_load  = ~main_valid | pop_ready;
  assign push.ready = ready_q;

  // ----------------------------------------------------------------------
  // Occupancy
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      ready_q    <= 1'b0;
    end else begin
      if (main_load) begin
        main_valid <= skid_valid | push_xfer;
        skid_valid <= 1'b0;
        ready_q    <= 1'b1;
      end else if (push_xfer) begin
        // Main is stalled, park the beat, both entries now full
        skid_valid <= 1'b1;
        ready_q    <= 1'b0;
      end
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (main_load) begin
      // Skid entry is older than anything on the push side
      main_data <= skid_valid ? skid_data : push.data;
      main_last <= skid_valid ? skid_last : push.last;
      main_flow <= skid_valid ? skid_flow : push.flow;
    end
    if (!main_load && push_xfer) begin
      skid_data <= push.data;
      skid_last <= push.last;
      skid_flow <= push.flow;
    end
  end

  assign pop_valid = main_valid;
  assign pop_data  = main_data;
  assign pop_last  = main_last;
  assign pop_flow  = main_flow;

endmodule

//--- hw/flow_sched_top.sv
/*
 * Packet scheduler top level.
 * Merges NumFlows ready-valid packet streams onto one tagged output stream,
 * round-robin per packet with a beat budget per grant.
 */

module flow_sched_top import flow_sched_pkg::*; #(
  // Number of input flows, at least 2
  parameter int NumFlows   = 2 ** FLOW_ID_W_DEFAULT,
  // Data beat width
  parameter int BitWidth   = DATA_W_DEFAULT,
  // Beat budget per grant, at least 1
  parameter int BurstBeats = 8
) (
  input  logic                              clk,
  input  logic                              reset,

  // Input flows
  input  logic [NumFlows-1:0]               push_valid,
  output logic [NumFlows-1:0]               push_ready,
  input  logic [NumFlows-1:0][BitWidth-1:0] push_data,
  input  logic [NumFlows-1:0]               push_last,

  // Scheduled output
  output logic                              pop_valid,
  input  logic                              pop_ready,
  output logic [BitWidth-1:0]               pop_data,
  output logic                              pop_last,
  output logic [$clog2(NumFlows)-1:0]       pop_flow
);

  localparam int SelW = $clog2(NumFlows);

  logic [SelW-1:0] select;
  logic            grant;
  logic            grant_start;
  logic            budget_reached;

  // Mux output into the skid buffer, watched by the FSM and the timer
  flow_if #(.BitWidth(BitWidth), .NumFlows(NumFlows)) mux_out ();

  // ----------------------------------------------------------------------
  // Control
  // ----------------------------------------------------------------------

  flow_sched_fsm #(.NumFlows(NumFlows)) u_fsm (
    .clk           (clk),
    .reset         (reset),
    .push_valid    (push_valid),
    .mon           (mux_out.mon),
    .budget_reached(budget_reached),
    .select        (select),
    .grant         (grant),
    .grant_start   (grant_start)
  );

  beat_budget_timer #(.BurstBeats(BurstBeats)) u_timer (
    .clk           (clk),
    .reset         (reset),
    .grant_start   (grant_start),
    .mon           (mux_out.mon),
    .budget_reached(budget_reached)
  );

  // ----------------------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------------------

  flow_mux_select #(.NumFlows(NumFlows), .BitWidth(BitWidth)) u_mux (
    .clk       (clk),
    .reset     (reset),
    .select    (select),
    .grant     (grant),
    .push_valid(push_valid),
    .push_data (push_data),
    .push_last (push_last),
    .push_ready(push_ready),
    .out       (mux_out.src)
  );

  flow_skid_buffer #(.BitWidth(BitWidth), .NumFlows(NumFlows)) u_skid (
    .clk      (clk),
    .reset    (reset),
    .push     (mux_out.snk),
    .pop_valid(pop_valid),
    .pop_ready(pop_ready),
    .pop_data (pop_data),
    .pop_last (pop_last),
    .pop_flow (pop_flow)
  );

endmodule

//--- verification/flow_sched_assertions.sv
/*
 * Protocol checks on the packet scheduler's top-level ports.
 * Bound into flow_sched_top by the testbench.
 */

module flow_sched_assert #(
  parameter int NumFlows = 4,
  parameter int BitWidth = 16
) (
  input logic                        clk,
  input logic                        reset,
  input logic [NumFlows-1:0]         push_ready,
  input logic                        pop_valid,
  input logic                        pop_ready,
  input logic [BitWidth-1:0]         pop_data,
  input logic                        pop_last,
  input logic [$clog2(NumFlows)-1:0] pop_flow
);

  // Number of failed checks
  int failures = 0;

  // A stalled output beat holds until the sink takes it
  stall_stable_a : assert property (
    @(posedge clk) disable iff (reset)
    pop_valid && !pop_ready |=>
      pop_valid && $stable(pop_data) && $stable(pop_last) && $stable(pop_flow)
  ) else begin
    failures++;
    $error("pop beat changed while stalled");
  end

  // Only the granted flow may see ready
  one_ready_a : assert property (
    @(posedge clk) disable iff (reset) $onehot0(push_ready)
  ) else begin
    failures++;
    $error("more than one push_ready bit high");
  end

  // Nothing moves in the cycle after a reset cycle
  reset_quiet_a : assert property (
    @(posedge clk) reset |=> (push_ready == '0) && !pop_valid
  ) else begin
    failures++;
    $error("push_ready or pop_valid high after reset");
  end

endmodule

//--- verification/flow_sched_tb.sv
/*
 * Directed testbench for the packet scheduler top level.
 * Four packet sources and the sink are driven on the falling edge. The packet
 * order is predicted from the round-robin and beat-budget rules.
 */

module flow_sched_tb;

  localparam int NumFlows   = 4;
  localparam int BitWidth   = 16;
  localparam int BurstBeats = 8;
  localparam int ClkPeriod  = 10;
  // Beats of tests 2 to 5 with test 5 at its largest
  localparam int PlannedBeats   = 5 + 12 + 27 + 48;
  localparam int WatchdogCycles = PlannedBeats * 20 + 400;

  logic                              clk;
  logic                              reset;
  logic [NumFlows-1:0]               push_valid;
  logic [NumFlows-1:0]               push_ready;
  logic [NumFlows-1:0][BitWidth-1:0] push_data;
  logic [NumFlows-1:0]               push_last;
  logic                              pop_valid;
  logic                              pop_ready;
  logic [BitWidth-1:0]               pop_data;
  logic                              pop_last;
  logic [$clog2(NumFlows)-1:0]       pop_flow;

  // Beats held as {last, data}
  logic [BitWidth:0]   tx_q    [NumFlows][$];
  logic [BitWidth:0]   exp_q   [NumFlows][$];
  int                  pkt_len [NumFlows][$];
  // Flow of each packet in output order when the order is predicted
  int                  order_q [$];
  // Beat on this flow transfers at the coming rising edge
  logic [NumFlows-1:0] fire;
  logic                rand_ready;
  logic                in_pkt;
  int                  cur_flow;
  integer              seed;
  int                  errors;
  int                  checks;

  flow_sched_top #(
    .NumFlows  (NumFlows),
    .BitWidth  (BitWidth),
    .BurstBeats(BurstBeats)
  ) u_dut (
    .clk       (clk),
    .reset     (reset),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .push_data (push_data),
    .push_last (push_last),
    .pop_valid (pop_valid),
    .pop_ready (pop_ready),
    .pop_data  (pop_data),
    .pop_last  (pop_last),
    .pop_flow  (pop_flow)
  );

  bind flow_sched_top flow_sched_assert #(
    .NumFlows(NumFlows),
    .BitWidth(BitWidth)
  ) u_assert (
    .clk       (clk),
    .reset     (reset),
    .push_ready(push_ready),
    .pop_valid (pop_valid),
    .pop_ready (pop_ready),
    .pop_data  (pop_data),
    .pop_last  (pop_last),
    .pop_flow  (pop_flow)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // ----------------------------------------------------------------------
  // Checking helpers
  // ----------------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("FAIL time %0t %s got %0h expected %0h", $time, name, got, expected);
    end
  endtask

  // One output beat, taken at the coming edge
  task automatic check_beat();
    logic [BitWidth:0] exp_beat;
    int                flow_id;
    flow_id = pop_flow;
    // Packets stay whole and start in the predicted flow order
    if (in_pkt) begin
      check_value("pop_flow", pop_flow, cur_flow);
    end else if (order_q.size() > 0) begin
      check_value("pop_flow", pop_flow, order_q.pop_front());
    end
    cur_flow = flow_id;
    in_pkt   = !pop_last;
    if (exp_q[flow_id].size() == 0) begin
      errors++;
      $display("Error at %0t: flow %0d put out a beat it never sent", $time, flow_id);
    end else begin
      exp_beat = exp_q[flow_id].pop_front();
      check_value("pop_data", pop_data, exp_beat[BitWidth-1:0]);
      check_value("pop_last", pop_last, exp_beat[BitWidth]);
    end
  endtask

  // ----------------------------------------------------------------------
  // Sources and sink
  // ----------------------------------------------------------------------

  // push_ready and pop_valid come from flops and already hold their values
  // for the coming rising edge
  always @(negedge clk) begin
    for (int f = 0; f < NumFlows; f++) begin
      if (fire[f]) begin
        void'(tx_q[f].pop_front());
      end
      push_valid[f] = (tx_q[f].size() > 0);
      {push_last[f], push_data[f]} = push_valid[f] ? tx_q[f][0] : '0;
      fire[f] = push_valid[f] & push_ready[f];
    end
    pop_ready = rand_ready ? 1'($random(seed)) : 1'b1;
    if (pop_valid && pop_ready) begin
      check_beat();
    end
  end

  task automatic add_packet(input int flow, input int len);
    logic [BitWidth:0] beat;
    for (int i = 0; i < len; i++) begin
      beat = {(i == len - 1), BitWidth'($random(seed))};
      tx_q[flow].push_back(beat);
      exp_q[flow].push_back(beat);
    end
    pkt_len[flow].push_back(len);
  endtask

  // Order model for packets all queued before reset is released
  task automatic predict_order();
    int lens [NumFlows][$];
    int sel;
    int beats;
    int left;
    lens = pkt_len;
    left = 0;
    sel  = 0;
    for (int f = 0; f < NumFlows; f++) begin
      left += lens[f].size();
    end
    while (left > 0) begin
      while (lens[sel].size() == 0) begin
        sel = (sel + 1) % NumFlows;
      end
      // Grant holds until a packet ends with the budget spent or none waits
      beats = 0;
      do begin
        beats += lens[sel].pop_front();
        order_q.push_back(sel);
        left--;
      end while (beats < BurstBeats && lens[sel].size() > 0);
      sel = (sel + 1) % NumFlows;
    end
  endtask

  // ----------------------------------------------------------------------
  // Sequencing
  // ----------------------------------------------------------------------

  // Leaves reset high at a rising edge so packets can be queued
  task automatic hold_reset();
    @(negedge clk);
    reset = 1'b1;
    repeat (16) @(posedge clk);
    for (int f = 0; f < NumFlows; f++) begin
      tx_q[f].delete();
      exp_q[f].delete();
      pkt_len[f].delete();
    end
    order_q.delete();
    fire   = '0;
    in_pkt = 1'b0;
  endtask

  task automatic release_reset();
    @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic wait_drained();
    int pending;
    do begin
      @(posedge clk);
      pending = 0;
      for (int f = 0; f < NumFlows; f++) begin
        pending += exp_q[f].size();
      end
    end while (pending != 0);
    if (in_pkt || order_q.size() != 0) begin
      errors++;
      $display("Error at %0t: a packet ended early or never arrived", $time);
    end
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------

  task automatic test_reset_state();
    hold_reset();
    @(negedge clk);
    check_value("pop_valid", pop_valid, 0);
    check_value("push_ready", push_ready, 0);
    reset = 1'b0;
    // Nothing may wake up after reset with idle inputs
    repeat (4) begin
      @(negedge clk);
      check_value("pop_valid", pop_valid, 0);
      check_value("push_ready", push_ready, 0);
    end
  endtask

  task automatic test_single_packet();
    hold_reset();
    add_packet(2, 5);
    predict_order();
    release_reset();
    wait_drained();
  endtask

  task automatic test_round_robin();
    hold_reset();
    for (int f = 0; f < NumFlows; f++) begin
      add_packet(f, 3);
    end
    predict_order();
    release_reset();
    wait_drained();
  endtask

  // Flow 1 spends its budget at its third packet and 12 beats run past it whole
  task automatic test_burst_budget();
    hold_reset();
    repeat (4) add_packet(1, 3);
    add_packet(2, 3);
    add_packet(3, 12);
    predict_order();
    release_reset();
    wait_drained();
  endtask

  task automatic test_back_pressure();
    hold_reset();
    rand_ready = 1'b1;
    for (int p = 0; p < 4; p++) begin
      add_packet((p % 2) * 2, 1 + $unsigned($random(seed)) % 6);
    end
    release_reset();
    // Late traffic on the odd flows lands mid-run
    repeat (10) @(posedge clk);
    for (int p = 0; p < 4; p++) begin
      add_packet((p % 2) * 2 + 1, 1 + $unsigned($random(seed)) % 6);
    end
    wait_drained();
    rand_ready = 1'b0;
  endtask

  initial begin
    seed       = 32'h051e_49d0;
    clk        = 1'b0;
    reset      = 1'b1;
    push_valid = '0;
    push_data  = '0;
    push_last  = '0;
    pop_ready  = 1'b0;
    rand_ready = 1'b0;
    fire       = '0;
    in_pkt     = 1'b0;
    cur_flow   = 0;
    errors     = 0;
    checks     = 0;
    test_reset_state();
    test_single_packet();
    test_round_robin();
    test_burst_budget();
    test_back_pressure();
    // Protocol checks bound into the DUT
    errors += u_dut.u_assert.failures;
    $display("Result: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog sized from the planned traffic
  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Timeout: tests still running after %0d cycles", WatchdogCycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- src.f
hw/flow_sched_pkg.sv
hw/flow_if.sv
hw/flow_mux_select.sv
hw/flow_sched_fsm.sv
hw/beat_budget_timer.sv
hw/flow_skid_buffer.sv
hw/flow_sched_top.sv
verification/flow_sched_assertions.sv
verification/flow_sched_tb.sv
